// ==== verilog/hyper_rx_pkg.sv ====
// Receive path package: sizes, memory-select mode codes and the PHY word union
package hyper_rx_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Width of byte and beat counts
  localparam int TRANS_SIZE = 16;

  // Destination FIFO entries, kept a power of two so the pointers wrap freely
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////
  // Memory-select modes
  //////////////////////////////

  // 16-bit beats, low byte first
  localparam logic [1:0] MODE_16      = 2'b00;
  // 16-bit beats, high byte first (HyperRAM)
  localparam logic [1:0] MODE_16_SWAP = 2'b10;
  // 32-bit beats (PSRAM x32)
  localparam logic [1:0] MODE_32      = 2'b11;

  //////////////////////////////
  // PHY word
  //////////////////////////////

  // One PHY beat, seen as a whole word or as the two bytes of a half word
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] rsvd;
      logic [7:0]  hi;
      logic [7:0]  lo;
    } half;
  } phy_word_u;

endpackage

// ==== verilog/hyper_rx_counter.sv ====
// Transfer beat counter: beat total at start, countdown on accepted beats, busy flag
`timescale 1ns/100ps

module hyper_rx_counter (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                start_i,
  input  logic [hyper_rx_pkg::TRANS_SIZE-1:0] cfg_rx_size_i,
  input  logic [1:0]                          cfg_mode_i,
  input  logic                                cfg_odd_addr_i,
  input  logic                                beat_i,
  output logic [hyper_rx_pkg::TRANS_SIZE-1:0] remained_o,
  output logic                                busy_o
);

  import hyper_rx_pkg::*;

  logic [TRANS_SIZE:0]   nb_bytes;
  logic [TRANS_SIZE-1:0] beat_total;

  // Bytes on the wire, including the dropped byte of an odd start address
  assign nb_bytes = {1'b0, cfg_rx_size_i} + {{TRANS_SIZE{1'b0}}, cfg_odd_addr_i};

  // Round up to whole beats
  always_comb
  begin
    if (cfg_mode_i == MODE_32)
      beat_total = TRANS_SIZE'((nb_bytes >> 2) + {{TRANS_SIZE{1'b0}}, |nb_bytes[1:0]});
    else
      beat_total = TRANS_SIZE'((nb_bytes >> 1) + {{TRANS_SIZE{1'b0}}, nb_bytes[0]});
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      remained_o <= '0;
    else if (start_i)
      remained_o <= beat_total;
    else if (beat_i)
      remained_o <= remained_o - TRANS_SIZE'(1);
  end

  assign busy_o = |remained_o;

  // PHY must stop once the last beat of the transfer is in
  a_no_extra_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_i |-> (remained_o != '0))
    else $error("beat accepted with no beats remaining");

  // A new transfer only starts after the previous one has drained
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o)
    else $error("start while a transfer is busy");

endmodule

// ==== verilog/hyper_rx_buffer.sv ====
// Receive buffer: 16-to-32 packing, HyperRAM byte swap, odd-address shift, tail masking
`timescale 1ns/100ps

module hyper_rx_buffer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [hyper_rx_pkg::TRANS_SIZE-1:0] cfg_rx_size_i,
  input  logic [1:0]                          cfg_mode_i,
  input  logic                                cfg_odd_addr_i,
  input  logic [hyper_rx_pkg::TRANS_SIZE-1:0] remained_i,
  input  logic                                phy_valid_i,
  input  logic                                phy_ready_i,
  input  logic [31:0]                         phy_data_i,
  output logic                                word_valid_o,
  output logic [31:0]                         word_data_o,
  output logic                                last_word_o
);

  import hyper_rx_pkg::*;

  phy_word_u             beat_w;
  logic [15:0]           beat_half;
  logic                  mode_32;
  logic                  beat_acc;
  logic                  beat_last;

  logic                  sel_q;
  logic [31:0]           pack_q;
  logic                  int_valid_q;
  logic                  last_q;

  logic [31:0]           prev_q;
  logic                  prev_vld_q;
  logic                  last_buf_q;
  logic                  tail_valid_q;
  logic                  need_tail;
  logic [31:0]           word_rot;

  logic [31:0]           out_word;
  logic                  out_last;
  logic [TRANS_SIZE-1:0] nb_words;
  logic [TRANS_SIZE-1:0] word_cnt_q;

  assign beat_w    = phy_data_i;
  assign mode_32   = (cfg_mode_i == MODE_32);
  assign beat_acc  = phy_valid_i & phy_ready_i;
  assign beat_last = (remained_i == TRANS_SIZE'(1));

  // HyperRAM sends the high byte first
  assign beat_half = (cfg_mode_i == MODE_16_SWAP) ? {beat_w.half.lo, beat_w.half.hi}
                                                  : beat_w.word[15:0];

  //////////////////////////////
  // 16b/32b packing
  //////////////////////////////

  // Half select, back to the low half after the last beat
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      sel_q <= 1'b0;
    else if (beat_acc)
      sel_q <= ~mode_32 & ~sel_q & ~beat_last;
  end

  always_ff @(posedge clk_i)
  begin
    if (beat_acc)
    begin
      if (mode_32)
        pack_q <= beat_w.word;
      else if (sel_q)
        pack_q[31:16] <= beat_half;
      else
        pack_q[15:0] <= beat_half;
    end
  end

  // Word complete: upper half, any x32 beat or the final beat
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      int_valid_q <= 1'b0;
      last_q      <= 1'b0;
    end
    else
    begin
      int_valid_q <= beat_acc & (mode_32 | sel_q | beat_last);
      last_q      <= beat_acc & beat_last;
    end
  end

  //////////////////////////////
  // Odd start address
  //////////////////////////////

  // Tail word needed when the shifted stream ends inside the final packed word
  assign need_tail = |cfg_rx_size_i[1:0];

  always_ff @(posedge clk_i)
  begin
    if (int_valid_q)
      prev_q <= pack_q;
  end

  // The tail waits for FIFO room like a beat would
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      prev_vld_q   <= 1'b0;
      last_buf_q   <= 1'b0;
      tail_valid_q <= 1'b0;
    end
    else
    begin
      if (int_valid_q)
        prev_vld_q <= ~last_q;
      if (int_valid_q & last_q & need_tail & cfg_odd_addr_i)
        last_buf_q <= 1'b1;
      else if (last_buf_q & phy_ready_i)
        last_buf_q <= 1'b0;
      tail_valid_q <= last_buf_q & phy_ready_i;
    end
  end

  // Low byte of the next word completes the previous one
  assign word_rot = tail_valid_q ? {8'h00, prev_q[31:8]} : {pack_q[7:0], prev_q[31:8]};

  //////////////////////////////
  // Output and tail mask
  //////////////////////////////

  always_comb
  begin
    if (cfg_odd_addr_i)
    begin
      word_valid_o = (int_valid_q & prev_vld_q) | tail_valid_q;
      out_word     = word_rot;
      out_last     = tail_valid_q | (last_q & ~need_tail);
    end
    else
    begin
      word_valid_o = int_valid_q;
      out_word     = pack_q;
      out_last     = last_q;
    end
  end

  always_comb
  begin
    word_data_o = out_word;
    if (out_last)
    begin
      case (cfg_rx_size_i[1:0])
        2'b01:   word_data_o = {24'h000000, out_word[7:0]};
        2'b10:   word_data_o = {16'h0000, out_word[15:0]};
        2'b11:   word_data_o = {8'h00, out_word[23:0]};
        default: word_data_o = out_word;
      endcase
    end
  end

  // Emitted words of the current transfer
  assign nb_words = (cfg_rx_size_i >> 2) + TRANS_SIZE'(need_tail);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      word_cnt_q  <= '0;
      last_word_o <= 1'b0;
    end
    else
    begin
      last_word_o <= word_valid_o & out_last;
      if (last_word_o)
        word_cnt_q <= '0;
      else if (word_valid_o)
        word_cnt_q <= word_cnt_q + TRANS_SIZE'(1);
    end
  end

  // No word beyond ceil(size/4) reaches the FIFO
  a_word_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_o |-> (word_cnt_q < nb_words))
    else $error("more words emitted than the transfer holds");

endmodule

// ==== verilog/hyper_rx_fifo.sv ====
// Destination word FIFO with registered early ready
`timescale 1ns/100ps

module hyper_rx_fifo (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wr_valid_i,
  input  logic [31:0] wr_data_i,
  output logic        wr_ready_o,
  output logic        rd_valid_o,
  input  logic        rd_ready_i,
  output logic [31:0] rd_data_o
);

  import hyper_rx_pkg::*;

  logic [31:0]           mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic [FIFO_CNT_W-1:0] count_next;
  logic                  do_rd;

  assign do_rd      = rd_valid_o & rd_ready_i;
  assign count_next = count_q + FIFO_CNT_W'(wr_valid_i) - FIFO_CNT_W'(do_rd);

  always_ff @(posedge clk_i)
  begin
    if (wr_valid_i)
      mem_q[wr_ptr_q] <= wr_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      wr_ready_o <= 1'b0;
    end
    else
    begin
      if (wr_valid_i)
        wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);
      if (do_rd)
        rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
      count_q <= count_next;
      // Two free entries cover the words still inside the buffer
      wr_ready_o <= (FIFO_CNT_W'(FIFO_DEPTH) - count_next) >= FIFO_CNT_W'(2);
    end
  end

  assign rd_valid_o = (count_q != '0);
  assign rd_data_o  = mem_q[rd_ptr_q];

  // The buffer has no stall, so early ready must keep it from overrunning
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_i |-> (count_q < FIFO_CNT_W'(FIFO_DEPTH)))
    else $error("write into a full FIFO");

endmodule

// ==== verilog/hyper_rx_top.sv ====
// Receive path top: counter, receive buffer and destination FIFO
`timescale 1ns/100ps

module hyper_rx_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                start_i,
  input  logic [hyper_rx_pkg::TRANS_SIZE-1:0] cfg_rx_size_i,
  input  logic [1:0]                          cfg_mode_i,
  input  logic                                cfg_odd_addr_i,
  input  logic                                phy_valid_i,
  input  logic [31:0]                         phy_data_i,
  output logic                                phy_ready_o,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [31:0]                         out_data_o,
  output logic                                done_o
);

  import hyper_rx_pkg::*;

  logic [TRANS_SIZE-1:0] remained;
  logic                  busy;
  logic                  beat;
  logic                  word_valid;
  logic [31:0]           word_data;
  logic                  last_word;

  // Accepted PHY beat
  assign beat = phy_valid_i & phy_ready_o;

  // All beats counted and the final word handed to the FIFO
  assign done_o = ~busy & last_word;

  hyper_rx_counter hyper_rx_counter_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .cfg_rx_size_i  (cfg_rx_size_i),
    .cfg_mode_i     (cfg_mode_i),
    .cfg_odd_addr_i (cfg_odd_addr_i),
    .beat_i         (beat),
    .remained_o     (remained),
    .busy_o         (busy)
  );

  hyper_rx_buffer hyper_rx_buffer_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cfg_rx_size_i  (cfg_rx_size_i),
    .cfg_mode_i     (cfg_mode_i),
    .cfg_odd_addr_i (cfg_odd_addr_i),
    .remained_i     (remained),
    .phy_valid_i    (phy_valid_i),
    .phy_ready_i    (phy_ready_o),
    .phy_data_i     (phy_data_i),
    .word_valid_o   (word_valid),
    .word_data_o    (word_data),
    .last_word_o    (last_word)
  );

  hyper_rx_fifo hyper_rx_fifo_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (word_valid),
    .wr_data_i  (word_data),
    .wr_ready_o (phy_ready_o),
    .rd_valid_o (out_valid_o),
    .rd_ready_i (out_ready_i),
    .rd_data_o  (out_data_o)
  );

endmodule

// ==== verification/hyper_rx_model.svh ====
// Reference model tasks: random beats of one transfer and the expected word stream
// Beats on the wire: bytes = size plus the odd byte, rounded up to whole beats
task automatic build_beats(input int size, input logic [1:0] mode, input logic odd);
  int nb_bytes;
  int nb_beats;
  nb_bytes = size + int'(odd);
  if (mode == MODE_32)
    nb_beats = (nb_bytes + 3) / 4;
  else
    nb_beats = (nb_bytes + 1) / 2;
  beat_q.delete();
  for (int i = 0; i < nb_beats; i++)
    beat_q.push_back(rand_bits(32));
endtask

// Byte stream in wire order, odd byte dropped, packed little-endian with a zero tail
task automatic build_expected(input int size, input logic [1:0] mode, input logic odd);
  logic [7:0]  stream [$];
  logic [31:0] word;
  foreach (beat_q[i])
  begin
    if (mode == MODE_32)
    begin
      for (int b = 0; b < 4; b++)
        stream.push_back(beat_q[i][8*b +: 8]);
    end
    else if (mode == MODE_16_SWAP)
    begin
      stream.push_back(beat_q[i][15:8]);
      stream.push_back(beat_q[i][7:0]);
    end
    else
    begin
      stream.push_back(beat_q[i][7:0]);
      stream.push_back(beat_q[i][15:8]);
    end
  end
  if (odd)
    void'(stream.pop_front());
  exp_q.delete();
  for (int w = 0; w < (size + 3) / 4; w++)
  begin
    word = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (4 * w + b < size)
        word[8*b +: 8] = stream[4 * w + b];
    end
    exp_q.push_back(word);
  end
endtask

// ==== verification/hyper_rx_tb.sv ====
// Receive path testbench: clock, reset, LFSR stimulus, scoreboard checks and watchdog
`timescale 1ns/100ps

module hyper_rx_tb;

  import hyper_rx_pkg::*;

  localparam int NUM_TRANSFERS = 64;
  localparam int CLK_PERIOD    = 8;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  start_i;
  logic [TRANS_SIZE-1:0] cfg_rx_size_i;
  logic [1:0]            cfg_mode_i;
  logic                  cfg_odd_addr_i;
  logic                  phy_valid_i;
  logic [31:0]           phy_data_i;
  logic                  phy_ready_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic [31:0]           out_data_o;
  logic                  done_o;

  logic [31:0] lfsr_q;
  logic [31:0] beat_q [$];
  logic [31:0] exp_q [$];
  int          beat_idx;
  int          done_cnt;
  // Words held in the destination FIFO, from the write strobe and the reads
  int          fifo_fill;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hD000_0001) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  `include "hyper_rx_model.svh"

  hyper_rx_top hyper_rx_top_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .start_i        (start_i),
    .cfg_rx_size_i  (cfg_rx_size_i),
    .cfg_mode_i     (cfg_mode_i),
    .cfg_odd_addr_i (cfg_odd_addr_i),
    .phy_valid_i    (phy_valid_i),
    .phy_data_i     (phy_data_i),
    .phy_ready_o    (phy_ready_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_data_o     (out_data_o),
    .done_o         (done_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////
  // One clock of stimulus and checks
  //////////////////////////////

  task automatic run_cycle();
    int free_cnt;
    @(negedge clk_i);
    start_i  = 1'b0;
    free_cnt = FIFO_DEPTH - fifo_fill;
    assert (phy_ready_o == (free_cnt >= 2))
      else report_failure($sformatf("ERROR phy_ready_o = 0x%0h with 0x%0h free entries",
                                    phy_ready_o, free_cnt));
    if (done_o)
    begin
      done_cnt++;
      assert (done_cnt == 1)
        else report_failure("done_o pulsed more than once in one transfer");
      assert (beat_idx == beat_q.size())
        else report_failure("done_o fired before all beats were accepted");
      // Every expected word not yet read must sit in the FIFO
      assert (fifo_fill == exp_q.size())
        else report_failure($sformatf("ERROR fifo count = 0x%0h at done_o, expected 0x%0h",
                                      fifo_fill, exp_q.size()));
    end
    // Buffer word written into the FIFO at the next rising edge
    if (hyper_rx_top_inst.word_valid)
      fifo_fill++;
    out_ready_i = (rand_bits(1) != 0);
    if (out_valid_o && out_ready_i)
    begin
      assert (exp_q.size() != 0)
        else report_failure("a word was delivered while none was expected");
      assert (out_data_o == exp_q[0])
        else report_failure($sformatf("ERROR out_data_o = 0x%08h, expected 0x%08h",
                                      out_data_o, exp_q[0]));
      void'(exp_q.pop_front());
      fifo_fill--;
    end
    // Random gaps in the PHY strobe
    if (beat_idx < beat_q.size() && rand_bits(2) != 0)
    begin
      phy_valid_i = 1'b1;
      phy_data_i  = beat_q[beat_idx];
      if (phy_ready_o)
        beat_idx++;
    end
    else
      phy_valid_i = 1'b0;
  endtask

  task automatic run_transfer();
    int size;
    size           = int'(rand_bits(6)) % 40 + 1;
    cfg_mode_i     = 2'(rand_bits(2));
    cfg_odd_addr_i = (rand_bits(1) != 0);
    cfg_rx_size_i  = TRANS_SIZE'(size);
    build_beats(size, cfg_mode_i, cfg_odd_addr_i);
    build_expected(size, cfg_mode_i, cfg_odd_addr_i);
    beat_idx = 0;
    done_cnt = 0;
    start_i  = 1'b1;
    while (!(done_cnt == 1 && exp_q.size() == 0))
      run_cycle();
    // Idle cycles catch a stray word or a second done
    repeat (2)
      run_cycle();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    cfg_rx_size_i  = '0;
    cfg_mode_i     = MODE_16;
    cfg_odd_addr_i = 1'b0;
    phy_valid_i    = 1'b0;
    phy_data_i     = '0;
    out_ready_i    = 1'b0;
    lfsr_q         = 32'd94666;
    fifo_fill      = 0;
    repeat (4)
    begin
      @(negedge clk_i);
      assert (!out_valid_o && !done_o && !phy_ready_o)
        else report_failure($sformatf(
          "ERROR in reset out_valid_o = 0x%0h done_o = 0x%0h phy_ready_o = 0x%0h, expected 0x0",
          out_valid_o, done_o, phy_ready_o));
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (phy_ready_o)
      else report_failure("ERROR phy_ready_o = 0x0 one cycle after reset, expected 0x1");
    for (int t = 0; t < NUM_TRANSFERS; t++)
      run_transfer();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog, 200 cycles per transfer
  initial
  begin
    #(NUM_TRANSFERS * 200 * CLK_PERIOD);
    report_failure("Timeout: the transfers did not complete before the watchdog expired");
  end

endmodule

// ==== files.f ====
+incdir+verification
verilog/hyper_rx_pkg.sv
verilog/hyper_rx_counter.sv
verilog/hyper_rx_buffer.sv
verilog/hyper_rx_fifo.sv
verilog/hyper_rx_top.sv
verification/hyper_rx_tb.sv

// ==== Makefile ====
# Verilator build and run of the receive path testbench

TOP = hyper_rx_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
